/* bench/imuldiv_tb.sv */
/*
 * testbench for the multiply/divide unit with random and corner requests and stalls
 * a reference model and concurrent assertions check every response and handshake
 */
`timescale 1ns/1ps
`include "imuldiv_params.svh"

module imuldiv_tb;

  localparam int SEED         = 18;
  localparam int RESET_CYCLES = 5;
  localparam int LATENCY      = 33;
  localparam int MAX_STALL    = 8;
  localparam int NUM_DIRECTED = 6;
  localparam int NUM_TX       = 300;
  // every transaction plus stall and handshake overhead with 50% margin
  localparam int TIMEOUT      = NUM_TX * (LATENCY + MAX_STALL + 4) * 3 / 2;

  logic                       clk;
  logic                       reset;
  imuldiv_pkg::req_t          req;
  logic                       req_val;
  logic                       req_rdy;
  imuldiv_pkg::resp_t         resp;
  logic                       resp_val;
  logic                       resp_rdy;

  // monitor state updated on transfers
  logic [2*`IMULDIV_XLEN-1:0] exp_result;
  string                      cur_name;
  int                         lat_cnt = 0;
  int                         tx_count = 0;
  int                         cycle_cnt = 0;

  tb_clock u_clock (.clk(clk));

  imuldiv_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // --------------------------------------------------
  // error reporting and reference model
  // --------------------------------------------------

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  function automatic string op_label(input imuldiv_pkg::op_e op);
    case (op)
      imuldiv_pkg::OP_MUL: op_label = "MUL";
      imuldiv_pkg::OP_DIV: op_label = "DIV";
      default:             op_label = "DIVU";
    endcase
  endfunction

  // mul gives the signed product and div packs {remainder, quotient}
  function automatic logic [63:0] model_result(input imuldiv_pkg::op_e op,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
    int          sa;
    int          sb;
    logic [31:0] q;
    logic [31:0] r;
    sa = a;
    sb = b;
    q  = '0;
    r  = '0;
    model_result = '0;
    if (op == imuldiv_pkg::OP_MUL) begin
      model_result = longint'(sa) * longint'(sb);
    end else begin
      if (b == 32'd0) begin
        // zero divisor keeps the dividend as remainder
        r = a;
        if (op == imuldiv_pkg::OP_DIVU) q = 32'hffff_ffff;
        else q = (sa < 0) ? 32'd1 : 32'hffff_ffff;
      end else if (op == imuldiv_pkg::OP_DIVU) begin
        q = a / b;
        r = a % b;
      end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        // signed overflow case
        q = 32'h8000_0000;
        r = 32'd0;
      end else begin
        q = sa / sb;
        r = sa % sb;
      end
      model_result = {r, q};
    end
  endfunction

  // --------------------------------------------------
  // monitor, timeout and assertions
  // --------------------------------------------------

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) report_error("timeout, run did not finish within the cycle limit");
    if (reset) begin
      lat_cnt <= 0;
    end else if (req_val && req_rdy) begin
      exp_result <= model_result(req.op, req.a, req.b);
      cur_name   <= $sformatf("%s_%0d", op_label(req.op), tx_count);
      tx_count   <= tx_count + 1;
      lat_cnt    <= 1;
    end else if (resp_val && resp_rdy) begin
      lat_cnt    <= 0;
    end else if (lat_cnt != 0 && lat_cnt < LATENCY) begin
      lat_cnt <= lat_cnt + 1;
    end
  end

  a_reset: assert property (@(posedge clk) reset |=> (!resp_val && req_rdy))
    else report_error("after reset resp_val is not low or req_rdy is not high");

  a_result: assert property (@(posedge clk) disable iff (reset)
    (resp_val && resp_rdy) |-> (resp.result == exp_result))
    else report_error($sformatf("MISMATCH test=%s expected=%h actual=%h",
                                cur_name, $sampled(exp_result), $sampled(resp.result)));

  // no response and no new accept while the unit iterates
  a_busy: assert property (@(posedge clk) disable iff (reset)
    (lat_cnt != 0 && lat_cnt < LATENCY) |-> (!resp_val && !req_rdy))
    else report_error("response came early or req_rdy went high during the calculation");

  a_latency: assert property (@(posedge clk) disable iff (reset)
    (lat_cnt == LATENCY) |-> resp_val)
    else report_error("resp_val did not rise on the 33rd edge after the request");

  a_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp.result)))
    else report_error("response dropped or changed while stalled");

  a_serial: assert property (@(posedge clk) disable iff (reset) resp_val |-> !req_rdy)
    else report_error("req_rdy high while a response is pending");

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  // corners picked a quarter of the time
  function automatic logic [31:0] pick_operand();
    logic [31:0] corners [5];
    corners = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    if ($urandom_range(3, 0) == 0) pick_operand = corners[$urandom_range(4, 0)];
    else pick_operand = $urandom;
  endfunction

  // called on a rising edge and returns on the response transfer edge
  task automatic run_tx(input imuldiv_pkg::op_e op,
                        input logic [31:0] a,
                        input logic [31:0] b);
    int stall;
    stall = $urandom_range(MAX_STALL, 0);
    req.op  <= op;
    req.a   <= a;
    req.b   <= b;
    req_val <= 1'b1;
    do @(posedge clk); while (!(req_val && req_rdy));
    req_val <= 1'b0;
    do @(posedge clk); while (!resp_val);
    // hold off the response to exercise back-pressure
    repeat (stall) @(posedge clk);
    resp_rdy <= 1'b1;
    do @(posedge clk); while (!(resp_val && resp_rdy));
    resp_rdy <= 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    reset    = 1'b1;
    req.op   = imuldiv_pkg::OP_MUL;
    req.a    = '0;
    req.b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    // directed corners, overflow and zero divisors
    run_tx(imuldiv_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    run_tx(imuldiv_pkg::OP_DIV, 32'd1234567, 32'd0);
    run_tx(imuldiv_pkg::OP_DIV, 32'hffff_fff9, 32'd0);
    run_tx(imuldiv_pkg::OP_DIVU, 32'hdead_beef, 32'd0);
    run_tx(imuldiv_pkg::OP_MUL, 32'h8000_0000, 32'h8000_0000);
    run_tx(imuldiv_pkg::OP_MUL, 32'h7fff_ffff, 32'hffff_ffff);
    for (int i = NUM_DIRECTED; i < NUM_TX; i++) begin
      run_tx(imuldiv_pkg::op_e'($urandom_range(2, 0)), pick_operand(), pick_operand());
    end
    repeat (2) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* bench/tb_clock.sv */
/*
 * free-running testbench clock, starts low, 10 ns period by default
 */
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS = 10.0
) (
  output logic clk
);

  // half period per toggle
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

/* hdl/imuldiv_div_dpath.sv */
/*
 * restoring divider datapath, sequenced by the divider control FSM
 * result packs the remainder in the upper half and the quotient in the lower
 */
`timescale 1ns/1ps
`include "imuldiv_params.svh"

module imuldiv_div_dpath (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`IMULDIV_XLEN-1:0]     a,
  input  logic [`IMULDIV_XLEN-1:0]     b,
  // control levels from the FSM
  input  logic                         load,
  input  logic                         is_signed,
  input  logic                         iterate,
  input  logic                         sub_en,
  // status back to the FSM
  output logic                         counter_is_zero,
  output logic                         rem_ge_divisor,
  output logic [2*`IMULDIV_XLEN-1:0]   result
);

  localparam int unsigned XLEN  = `IMULDIV_XLEN;
  localparam int unsigned CNT_W = `IMULDIV_CNT_W;

  // ------------------------------------------------
  // operand conditioning
  // ------------------------------------------------

  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  // sign bits only count in signed mode
  assign a_neg = is_signed && a[XLEN-1];
  assign b_neg = is_signed && b[XLEN-1];

  // unsigned mode passes the raw operands through
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  // ------------------------------------------------
  // iteration state
  // ------------------------------------------------

  // quo_reg shifts dividend bits out at the top, quotient bits in at the bottom
  logic [XLEN-1:0]  quo_reg;
  logic [XLEN-1:0]  rem_reg;
  logic [XLEN-1:0]  dvs_reg;
  logic [CNT_W-1:0] cnt_reg;
  logic             q_neg_reg;
  logic             r_neg_reg;

  // partial remainder with the next dividend bit, one extra bit of headroom
  logic [XLEN:0]    rem_shift;
  logic [XLEN:0]    rem_diff;

  assign rem_shift = {rem_reg, quo_reg[XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, dvs_reg};

  // trial subtract succeeds, a zero divisor always passes
  assign rem_ge_divisor = (rem_shift >= {1'b0, dvs_reg});

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_reg <= '0;
    end else if (load) begin
      cnt_reg <= CNT_W'(XLEN - 1);
    end else if (iterate) begin
      cnt_reg <= cnt_reg - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      quo_reg   <= a_mag;
      rem_reg   <= '0;
      dvs_reg   <= b_mag;
      // quotient negative for mixed signs
      q_neg_reg <= a_neg ^ b_neg;
      // remainder follows the dividend
      r_neg_reg <= a_neg;
    end else if (iterate) begin
      // restore by keeping the shifted value when the subtract is skipped
      // without the subtract rem_shift is below the divisor, so it fits
      rem_reg <= sub_en ? rem_diff[XLEN-1:0] : rem_shift[XLEN-1:0];
      quo_reg <= {quo_reg[XLEN-2:0], sub_en};
    end
  end

  // ------------------------------------------------
  // status and result
  // ------------------------------------------------

  logic [XLEN-1:0] rem_out;
  logic [XLEN-1:0] quo_out;

  assign counter_is_zero = (cnt_reg == '0);

  // sign fix-up on both halves
  assign rem_out = r_neg_reg ? (~rem_reg + 1'b1) : rem_reg;
  assign quo_out = q_neg_reg ? (~quo_reg + 1'b1) : quo_reg;

  assign result = {rem_out, quo_out};

endmodule

/* hdl/imuldiv_div_iterative.sv */
/*
 * iterative divider for DIV and DIVU, control FSM around the restoring datapath
 * same val/rdy behaviour and latency as the multiplier
 */
`timescale 1ns/1ps
`include "imuldiv_params.svh"

module imuldiv_div_iterative (
  input  logic                         clk,
  input  logic                         reset,
  // request side
  input  logic                         req_val,
  output logic                         req_rdy,
  input  imuldiv_pkg::op_e             op,
  input  logic [`IMULDIV_XLEN-1:0]     a,
  input  logic [`IMULDIV_XLEN-1:0]     b,
  // response side
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output logic [2*`IMULDIV_XLEN-1:0]   result
);

  imuldiv_pkg::state_e state;
  imuldiv_pkg::state_e state_next;

  // control to the datapath
  logic load;
  logic is_signed;
  logic iterate;
  logic sub_en;

  // status from the datapath
  logic counter_is_zero;
  logic rem_ge_divisor;

  imuldiv_div_dpath u_dpath (
    .clk             (clk),
    .reset           (reset),
    .a               (a),
    .b               (b),
    .load            (load),
    .is_signed       (is_signed),
    .iterate         (iterate),
    .sub_en          (sub_en),
    .counter_is_zero (counter_is_zero),
    .rem_ge_divisor  (rem_ge_divisor),
    .result          (result)
  );

  // ------------------------------------------------
  // state register and transitions
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::ST_IDLE: begin
        if (req_val) begin
          state_next = imuldiv_pkg::ST_CALC;
        end
      end
      imuldiv_pkg::ST_CALC: begin
        if (counter_is_zero) begin
          state_next = imuldiv_pkg::ST_DONE;
        end
      end
      imuldiv_pkg::ST_DONE: begin
        // hold the response until the consumer takes it
        if (resp_rdy) begin
          state_next = imuldiv_pkg::ST_IDLE;
        end
      end
      default: state_next = imuldiv_pkg::ST_IDLE;
    endcase
  end

  // ------------------------------------------------
  // outputs and datapath controls
  // ------------------------------------------------

  assign req_rdy  = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val = (state == imuldiv_pkg::ST_DONE);

  assign load      = req_rdy && req_val;
  // only sampled by the datapath on load
  assign is_signed = (op == imuldiv_pkg::OP_DIV);
  assign iterate   = (state == imuldiv_pkg::ST_CALC);
  // subtract when the trial remainder covers the divisor, else restore
  assign sub_en    = iterate && rem_ge_divisor;

endmodule

/* hdl/imuldiv_mul_dpath.sv */
/*
 * shift-add multiplier datapath, sequenced by the multiplier control FSM
 * works on operand magnitudes and applies the product sign at the output
 */
`timescale 1ns/1ps
`include "imuldiv_params.svh"

module imuldiv_mul_dpath (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`IMULDIV_XLEN-1:0]     a,
  input  logic [`IMULDIV_XLEN-1:0]     b,
  // control levels from the FSM
  input  logic                         load,
  input  logic                         iterate,
  input  logic                         add_en,
  // status back to the FSM
  output logic                         counter_is_zero,
  output logic                         b_lsb,
  output logic [2*`IMULDIV_XLEN-1:0]   result
);

  localparam int unsigned XLEN  = `IMULDIV_XLEN;
  localparam int unsigned CNT_W = `IMULDIV_CNT_W;

  // ------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------

  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;

  // two's complement negate when the sign bit is set
  // most negative value maps to itself, read as unsigned it is correct
  assign a_mag = a[XLEN-1] ? (~a + 1'b1) : a;
  assign b_mag = b[XLEN-1] ? (~b + 1'b1) : b;

  // ------------------------------------------------
  // iteration state
  // ------------------------------------------------

  logic [2*XLEN-1:0] a_reg;
  logic [XLEN-1:0]   b_reg;
  logic [2*XLEN-1:0] acc_reg;
  logic [CNT_W-1:0]  cnt_reg;
  logic              sign_reg;

  // counter, loads XLEN-1 so the calc phase runs XLEN cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_reg <= '0;
    end else if (load) begin
      cnt_reg <= CNT_W'(XLEN - 1);
    end else if (iterate) begin
      cnt_reg <= cnt_reg - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      // multiplicand starts in the low half, zero extended
      a_reg    <= {{XLEN{1'b0}}, a_mag};
      b_reg    <= b_mag;
      acc_reg  <= '0;
      // product is negative when exactly one operand is
      sign_reg <= a[XLEN-1] ^ b[XLEN-1];
    end else if (iterate) begin
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
      // partial product only when the current multiplier bit is set
      if (add_en) begin
        acc_reg <= acc_reg + a_reg;
      end
    end
  end

  // ------------------------------------------------
  // status and result
  // ------------------------------------------------

  assign counter_is_zero = (cnt_reg == '0);
  assign b_lsb           = b_reg[0];

  // sign fix-up, held stable while nothing loads or iterates
  assign result = sign_reg ? (~acc_reg + 1'b1) : acc_reg;

endmodule

/* hdl/imuldiv_mul_iterative.sv */
/*
 * iterative multiplier, control FSM around the shift-add datapath
 * val/rdy on both sides, one product every XLEN+1 cycles
 */
`timescale 1ns/1ps
`include "imuldiv_params.svh"

module imuldiv_mul_iterative (
  input  logic                         clk,
  input  logic                         reset,
  // request side
  input  logic                         req_val,
  output logic                         req_rdy,
  input  logic [`IMULDIV_XLEN-1:0]     a,
  input  logic [`IMULDIV_XLEN-1:0]     b,
  // response side
  output logic                         resp_val,
  input  logic                         resp_rdy,
  output logic [2*`IMULDIV_XLEN-1:0]   result
);

  imuldiv_pkg::state_e state;
  imuldiv_pkg::state_e state_next;

  // control to the datapath
  logic load;
  logic iterate;
  logic add_en;

  // status from the datapath
  logic counter_is_zero;
  logic b_lsb;

  imuldiv_mul_dpath u_dpath (
    .clk             (clk),
    .reset           (reset),
    .a               (a),
    .b               (b),
    .load            (load),
    .iterate         (iterate),
    .add_en          (add_en),
    .counter_is_zero (counter_is_zero),
    .b_lsb           (b_lsb),
    .result          (result)
  );

  // ------------------------------------------------
  // state register and transitions
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::ST_IDLE: begin
        // rdy is high in idle, so val alone means accept
        if (req_val) begin
          state_next = imuldiv_pkg::ST_CALC;
        end
      end
      imuldiv_pkg::ST_CALC: begin
        // last iteration happens on this edge
        if (counter_is_zero) begin
          state_next = imuldiv_pkg::ST_DONE;
        end
      end
      imuldiv_pkg::ST_DONE: begin
        if (resp_rdy) begin
          state_next = imuldiv_pkg::ST_IDLE;
        end
      end
      default: state_next = imuldiv_pkg::ST_IDLE;
    endcase
  end

  // ------------------------------------------------
  // outputs and datapath controls
  // ------------------------------------------------

  assign req_rdy  = (state == imuldiv_pkg::ST_IDLE);
  assign resp_val = (state == imuldiv_pkg::ST_DONE);

  // operands, sign and counter load on the accept edge
  assign load    = req_rdy && req_val;
  assign iterate = (state == imuldiv_pkg::ST_CALC);
  // add the shifted multiplicand only for a set multiplier bit
  assign add_en  = iterate && b_lsb;

endmodule

/* hdl/imuldiv_params.svh */
/*
 * width constants for the multiply/divide unit
 * included by every RTL file that sizes operands or iteration counters
 */
`ifndef IMULDIV_PARAMS_SVH
`define IMULDIV_PARAMS_SVH

// ------------------------------------------------
// operand and counter widths
// ------------------------------------------------

// operand width, results are twice this wide
`define IMULDIV_XLEN 32

// iteration counter, counts XLEN-1 down to zero
`define IMULDIV_CNT_W 5

`endif

/* hdl/imuldiv_pkg.sv */
/*
 * shared types for the multiply/divide unit
 * opcodes, FSM states and the request/response structs
 */
`include "imuldiv_params.svh"

package imuldiv_pkg;

  // ------------------------------------------------
  // enums
  // ------------------------------------------------

  // unit opcodes, remainder comes back with the quotient
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_DIV  = 2'd1,
    OP_DIVU = 2'd2
  } op_e;

  // shared by the multiplier and divider control FSMs
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } state_e;

  // ------------------------------------------------
  // message structs
  // ------------------------------------------------

  typedef struct packed {
    op_e                     op;
    logic [`IMULDIV_XLEN-1:0] a;
    logic [`IMULDIV_XLEN-1:0] b;
  } req_t;

  // div packs {remainder, quotient}, mul is the full product
  typedef struct packed {
    logic [2*`IMULDIV_XLEN-1:0] result;
  } resp_t;

endpackage

/* hdl/imuldiv_top.sv */
/*
 * multiply/divide unit top level, steers each request to the multiplier or
 * divider by opcode and serializes to one transaction in flight
 */
`timescale 1ns/1ps
`include "imuldiv_params.svh"

module imuldiv_top (
  input  logic                clk,
  input  logic                reset,
  input  imuldiv_pkg::req_t   req,
  input  logic                req_val,
  output logic                req_rdy,
  output imuldiv_pkg::resp_t  resp,
  output logic                resp_val,
  input  logic                resp_rdy
);

  // ------------------------------------------------
  // opcode decode and request steering
  // ------------------------------------------------

  logic is_mul;
  logic is_div;
  logic in_flight;

  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic div_req_val;
  logic div_req_rdy;
  logic div_resp_val;

  logic [2*`IMULDIV_XLEN-1:0] mul_result;
  logic [2*`IMULDIV_XLEN-1:0] div_result;

  assign is_mul = (req.op == imuldiv_pkg::OP_MUL);
  assign is_div = (req.op == imuldiv_pkg::OP_DIV) || (req.op == imuldiv_pkg::OP_DIVU);

  // no new request reaches a unit while one is outstanding
  assign mul_req_val = req_val && is_mul && !in_flight;
  assign div_req_val = req_val && is_div && !in_flight;

  // rdy of the selected unit only
  assign req_rdy = !in_flight && ((is_mul && mul_req_rdy) || (is_div && div_req_rdy));

  // set on accept, cleared when the response leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= 1'b0;
    end else if (req_val && req_rdy) begin
      in_flight <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      in_flight <= 1'b0;
    end
  end

  // ------------------------------------------------
  // units
  // ------------------------------------------------

  imuldiv_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .a        (req.a),
    .b        (req.b),
    .resp_val (mul_resp_val),
    .resp_rdy (resp_rdy),
    .result   (mul_result)
  );

  imuldiv_div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .op       (req.op),
    .a        (req.a),
    .b        (req.b),
    .resp_val (div_resp_val),
    .resp_rdy (resp_rdy),
    .result   (div_result)
  );

  // ------------------------------------------------
  // response merge
  // ------------------------------------------------

  // at most one unit holds a response at a time
  assign resp_val    = mul_resp_val || div_resp_val;
  assign resp.result = mul_resp_val ? mul_result : div_result;

endmodule

/* project.f */
+incdir+hdl
hdl/imuldiv_pkg.sv
hdl/imuldiv_mul_dpath.sv
hdl/imuldiv_mul_iterative.sv
hdl/imuldiv_div_dpath.sv
hdl/imuldiv_div_iterative.sv
hdl/imuldiv_top.sv
bench/tb_clock.sv
bench/imuldiv_tb.sv
